//--- controlGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlGen import decodePkg::*; (
        input  logic      clk,
        input  logic      reset,
        input  logic      instrValid,
        input  instrKindT kind,
        output logic      ctrlValid,
        output controlT   ctrl
);

        controlT ctrlNext;

        ////////////////////////////////////////
        // Kind to control bundle
        ////////////////////////////////////////
        always_comb begin
                ctrlNext = '{aluOp: aluNone, srcA: srcARegs, srcB: srcBRegs,
                             extOp: extZero, wbSel: wbAluOut, dstSel: dstRd,
                             readSel: readRf, regsWr: '0, isBranch: 1'b0,
                             branchCode: brEq, isImmeJump: 1'b0, invalid: 1'b0};

                // Per kind codes
                case (kind)
                        kindAdd, kindAddi:                     ctrlNext.aluOp = aluAdd;
                        kindAddu, kindAddiu, kindMthi, kindMtlo: ctrlNext.aluOp = aluAddu;
                        kindSub:                               ctrlNext.aluOp = aluSub;
                        kindSubu:                              ctrlNext.aluOp = aluSubu;
                        kindSlt, kindSlti:                     ctrlNext.aluOp = aluSlt;
                        kindSltu, kindSltiu:                   ctrlNext.aluOp = aluSltu;
                        kindAnd, kindAndi:                     ctrlNext.aluOp = aluAnd;
                        kindOr, kindOri:                       ctrlNext.aluOp = aluOr;
                        kindXor, kindXori:                     ctrlNext.aluOp = aluXor;
                        kindNor:                               ctrlNext.aluOp = aluNor;
                        kindLui:                               ctrlNext.aluOp = aluLui;
                        kindSll, kindSllv:                     ctrlNext.aluOp = aluSll;
                        kindSrl, kindSrlv:                     ctrlNext.aluOp = aluSrl;
                        kindSra, kindSrav:                     ctrlNext.aluOp = aluSra;
                        kindMult:                              ctrlNext.aluOp = aluMult;
                        kindMultu:                             ctrlNext.aluOp = aluMultu;
                        kindDiv:                               ctrlNext.aluOp = aluDiv;
                        kindDivu:                              ctrlNext.aluOp = aluDivu;
                        kindBeq:                               ctrlNext.branchCode = brEq;
                        kindBne:                               ctrlNext.branchCode = brNe;
                        kindBlez:                              ctrlNext.branchCode = brLe;
                        kindBgtz:                              ctrlNext.branchCode = brGt;
                        kindBltz, kindBltzal:                  ctrlNext.branchCode = brLt;
                        kindBgez, kindBgezal:                  ctrlNext.branchCode = brGe;
                        kindJr, kindJalr:                      ctrlNext.branchCode = brReg;
                        kindInvalid:                           ctrlNext.invalid = 1'b1;
                        default:                               ctrlNext.aluOp = aluNone;
                endcase

                // Immediate forms write rt
                if (kind inside {kindAddi, kindAddiu, kindSlti, kindSltiu,
                                 kindAndi, kindOri, kindXori, kindLui}) begin
                        ctrlNext.srcB   = srcBImm;
                        ctrlNext.dstSel = dstRt;
                end
                if (kind inside {kindAddi, kindAddiu, kindSlti, kindSltiu, kindBeq, kindBne,
                                 kindBlez, kindBgtz, kindBltz, kindBgez, kindBltzal,
                                 kindBgezal}) begin
                        ctrlNext.extOp = extSign;
                end
                if (kind == kindLui) begin
                        ctrlNext.extOp = extUpper;      // Imm into the top half
                end
                if (kind inside {kindSll, kindSrl, kindSra}) begin
                        ctrlNext.srcA = srcAShamt;
                end

                ////////////////////////////////////////
                // Write enables
                ////////////////////////////////////////
                ctrlNext.regsWr.rfEn = kind inside {kindAdd, kindAddu, kindSub, kindSubu,
                                kindSlt, kindSltu, kindAnd, kindOr, kindXor, kindNor,
                                kindAddi, kindAddiu, kindSlti, kindSltiu, kindAndi, kindOri,
                                kindXori, kindLui, kindSll, kindSrl, kindSra, kindSllv,
                                kindSrlv, kindSrav, kindMfhi, kindMflo, kindBltzal,
                                kindBgezal, kindJal, kindJalr};
                ctrlNext.regsWr.hiEn = kind inside {kindMult, kindMultu, kindDiv, kindDivu,
                                kindMthi};
                ctrlNext.regsWr.loEn = kind inside {kindMult, kindMultu, kindDiv, kindDivu,
                                kindMtlo};

                // HI/LO reads go out through write-back
                if (kind inside {kindMfhi, kindMflo}) begin
                        ctrlNext.wbSel   = wbHiLo;
                        ctrlNext.readSel = (kind == kindMfhi) ? readHi : readLo;
                end

                // Control transfer
                ctrlNext.isBranch   = kind inside {kindBeq, kindBne, kindBlez, kindBgtz,
                                kindBltz, kindBgez, kindBltzal, kindBgezal, kindJr, kindJalr};
                ctrlNext.isImmeJump = kind inside {kindJ, kindJal};
                if (kind inside {kindBltzal, kindBgezal, kindJal, kindJalr}) begin
                        ctrlNext.wbSel = wbLink;        // Return address
                end
                if (kind inside {kindBltzal, kindBgezal, kindJal}) begin
                        ctrlNext.dstSel = dstLink;      // jalr keeps rd
                end
        end

        ////////////////////////////////////////
        // Output register
        ////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (reset) begin
                        ctrlValid <= 1'b0;
                        ctrl      <= '0;
                end else begin
                        ctrlValid <= instrValid;
                        if (instrValid) begin
                                ctrl <= ctrlNext;       // Hold during idle cycles
                        end
                end
        end

endmodule

`default_nettype wire

//--- decodeCases.txt
// Columns: instruction word (32-bit hex), expected controlT bundle (24-bit hex)
// Bundle bits: aluOp 23:19, srcA 18, srcB 17, extOp 16:15, wbSel 14:13, dstSel 12:11, ...
00221820 000100 // add
00221823 180100 // subu
0022182b 280100 // sltu
00221827 480100 // nor
2022fff0 028900 // addi
24220010 0a8900 // addiu
2822ffff 228900 // slti
2c228000 2a8900 // sltiu
3022ff00 320900 // andi
342200ff 3a0900 // ori
3822abcd 420900 // xori
3c021234 530900 // lui
00021900 5c0100 // sll
00021903 6c0100 // sra
00221806 600100 // srlv
00220018 7000c0 // mult
0022001b 8800c0 // divu
00001810 904300 // mfhi
00001812 904500 // mflo
00200011 080080 // mthi
00200013 080040 // mtlo
10220004 908020 // beq
1422fffc 908024 // bne
18200010 908028 // blez
1c200010 90802c // bgtz
04200008 908030 // bltz
04210008 908034 // bgez
04300008 90b130 // bltzal
04310008 90b134 // bgezal
08100000 900002 // j
0c100040 903102 // jal
03e00008 900038 // jr
0020f809 902138 // jalr
8c220004 900001 // lw, reserved here
ac220004 900001 // sw, reserved here
0022183f 900001 // unknown funct
00221900 900001 // sll with nonzero rs

//--- decodePkg.sv
`default_nettype none

package decodePkg;

        ////////////////////////////////////////
        // Widths and fixed registers
        ////////////////////////////////////////
        localparam int InstrWidth   = 32;
        localparam int RegAddrWidth = 5;
        localparam int LinkReg      = 31;       // Target of bltzal, bgezal and jal

        // Opcodes
        localparam logic [5:0] opSpecial = 6'b000000;
        localparam logic [5:0] opRegImm  = 6'b000001;
        localparam logic [5:0] opJ       = 6'b000010;
        localparam logic [5:0] opJal     = 6'b000011;
        localparam logic [5:0] opBeq     = 6'b000100;
        localparam logic [5:0] opBne     = 6'b000101;
        localparam logic [5:0] opBlez    = 6'b000110;
        localparam logic [5:0] opBgtz    = 6'b000111;
        localparam logic [5:0] opAddi    = 6'b001000;
        localparam logic [5:0] opAddiu   = 6'b001001;
        localparam logic [5:0] opSlti    = 6'b001010;
        localparam logic [5:0] opSltiu   = 6'b001011;
        localparam logic [5:0] opAndi    = 6'b001100;
        localparam logic [5:0] opOri     = 6'b001101;
        localparam logic [5:0] opXori    = 6'b001110;
        localparam logic [5:0] opLui     = 6'b001111;

        // SPECIAL group funct codes
        localparam logic [5:0] functSll   = 6'b000000;
        localparam logic [5:0] functSrl   = 6'b000010;
        localparam logic [5:0] functSra   = 6'b000011;
        localparam logic [5:0] functSllv  = 6'b000100;
        localparam logic [5:0] functSrlv  = 6'b000110;
        localparam logic [5:0] functSrav  = 6'b000111;
        localparam logic [5:0] functJr    = 6'b001000;
        localparam logic [5:0] functJalr  = 6'b001001;
        localparam logic [5:0] functMfhi  = 6'b010000;
        localparam logic [5:0] functMthi  = 6'b010001;
        localparam logic [5:0] functMflo  = 6'b010010;
        localparam logic [5:0] functMtlo  = 6'b010011;
        localparam logic [5:0] functMult  = 6'b011000;
        localparam logic [5:0] functMultu = 6'b011001;
        localparam logic [5:0] functDiv   = 6'b011010;
        localparam logic [5:0] functDivu  = 6'b011011;
        localparam logic [5:0] functAdd   = 6'b100000;
        localparam logic [5:0] functAddu  = 6'b100001;
        localparam logic [5:0] functSub   = 6'b100010;
        localparam logic [5:0] functSubu  = 6'b100011;
        localparam logic [5:0] functAnd   = 6'b100100;
        localparam logic [5:0] functOr    = 6'b100101;
        localparam logic [5:0] functXor   = 6'b100110;
        localparam logic [5:0] functNor   = 6'b100111;
        localparam logic [5:0] functSlt   = 6'b101010;
        localparam logic [5:0] functSltu  = 6'b101011;

        // REGIMM group rt codes
        localparam logic [RegAddrWidth-1:0] rtBltz   = 5'b00000;
        localparam logic [RegAddrWidth-1:0] rtBgez   = 5'b00001;
        localparam logic [RegAddrWidth-1:0] rtBltzal = 5'b10000;
        localparam logic [RegAddrWidth-1:0] rtBgezal = 5'b10001;

        ////////////////////////////////////////
        // Instruction word views
        ////////////////////////////////////////
        typedef struct packed {
                logic [5:0]              opcode;
                logic [RegAddrWidth-1:0] rs;
                logic [RegAddrWidth-1:0] rt;
                logic [RegAddrWidth-1:0] rd;
                logic [4:0]              shamt;
                logic [5:0]              funct;
        } rFormatT;

        typedef struct packed {
                logic [5:0]              opcode;
                logic [RegAddrWidth-1:0] rs;
                logic [RegAddrWidth-1:0] rt;
                logic [InstrWidth/2-1:0] imm;
        } iFormatT;

        typedef struct packed {
                logic [5:0]            opcode;
                logic [InstrWidth-7:0] target;  // Word index inside the 256 MB region
        } jFormatT;

        typedef union packed {
                rFormatT r;
                iFormatT i;
                jFormatT j;
        } instrWordT;

        typedef enum logic [5:0] {
                kindInvalid,
                kindAdd, kindAddu, kindSub, kindSubu, kindSlt, kindSltu,
                kindAnd, kindOr, kindXor, kindNor,
                kindAddi, kindAddiu, kindSlti, kindSltiu,
                kindAndi, kindOri, kindXori, kindLui,
                kindSll, kindSrl, kindSra, kindSllv, kindSrlv, kindSrav,
                kindMult, kindMultu, kindDiv, kindDivu,
                kindMfhi, kindMflo, kindMthi, kindMtlo,
                kindBeq, kindBne, kindBlez, kindBgtz,
                kindBltz, kindBgez, kindBltzal, kindBgezal,
                kindJ, kindJal, kindJr, kindJalr
        } instrKindT;

        ////////////////////////////////////////
        // Control encodings
        ////////////////////////////////////////
        typedef enum logic [4:0] {
                aluAdd, aluAddu, aluSub, aluSubu, aluSlt, aluSltu,
                aluAnd, aluOr, aluXor, aluNor, aluLui,
                aluSll, aluSrl, aluSra,
                aluMult, aluMultu, aluDiv, aluDivu,
                aluNone
        } aluOpT;

        typedef enum logic {srcARegs, srcAShamt} srcAT;
        typedef enum logic {srcBRegs, srcBImm} srcBT;
        typedef enum logic [1:0] {extZero, extSign, extUpper} extOpT;
        typedef enum logic [1:0] {wbAluOut, wbLink, wbHiLo} wbSelT;
        typedef enum logic [1:0] {dstRd, dstRt, dstLink} dstSelT;
        typedef enum logic [1:0] {readRf, readHi, readLo} readSelT;
        typedef enum logic [2:0] {brEq, brNe, brLe, brGt, brLt, brGe, brReg} branchCodeT;

        typedef struct packed {
                logic rfEn;
                logic hiEn;
                logic loEn;
        } regsWrT;

        // Field order matches the hex layout of the case file
        typedef struct packed {
                aluOpT      aluOp;
                srcAT       srcA;
                srcBT       srcB;
                extOpT      extOp;
                wbSelT      wbSel;
                dstSelT     dstSel;
                readSelT    readSel;
                regsWrT     regsWr;
                logic       isBranch;
                branchCodeT branchCode;
                logic       isImmeJump;
                logic       invalid;
        } controlT;

endpackage

`default_nettype wire

//--- decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*; (
        input  logic      clk,
        input  logic      reset,
        input  logic      instrValid,
        input  instrWordT instr,
        output logic      ctrlValid,
        output controlT   ctrl
);

        instrKindT kind;        // Combinational kind into the table

        ////////////////////////////////////////
        // Classify then expand
        ////////////////////////////////////////
        instrClassifier i_instrClassifier (
                .instr (instr),
                .kind  (kind)
        );

        controlGen i_controlGen (
                .clk        (clk),
                .reset      (reset),
                .instrValid (instrValid),
                .kind       (kind),
                .ctrlValid  (ctrlValid),
                .ctrl       (ctrl)
        );

endmodule

`default_nettype wire

//--- filelist.f
decodePkg.sv
instrClassifier.sv
controlGen.sv
decodeStage.sv
tbDecodeStage.sv

//--- instrClassifier.sv
`timescale 1ns/1ps
`default_nettype none

module instrClassifier import decodePkg::*; (
        input  instrWordT instr,
        output instrKindT kind
);

        ////////////////////////////////////////
        // Opcode group, then funct or rt
        ////////////////////////////////////////
        always_comb begin
                case (instr.r.opcode)
                        opSpecial: begin
                                case (instr.r.funct)
                                        functAdd:   kind = kindAdd;
                                        functAddu:  kind = kindAddu;
                                        functSub:   kind = kindSub;
                                        functSubu:  kind = kindSubu;
                                        functSlt:   kind = kindSlt;
                                        functSltu:  kind = kindSltu;
                                        functAnd:   kind = kindAnd;
                                        functOr:    kind = kindOr;
                                        functXor:   kind = kindXor;
                                        functNor:   kind = kindNor;
                                        functMult:  kind = kindMult;
                                        functMultu: kind = kindMultu;
                                        functDiv:   kind = kindDiv;
                                        functDivu:  kind = kindDivu;
                                        functMfhi:  kind = kindMfhi;
                                        functMflo:  kind = kindMflo;
                                        functMthi:  kind = kindMthi;
                                        functMtlo:  kind = kindMtlo;
                                        functJr:    kind = kindJr;
                                        functJalr:  kind = kindJalr;
                                        // Constant shifts need rs clear
                                        functSll:   kind = (instr.r.rs == '0) ? kindSll : kindInvalid;
                                        functSrl:   kind = (instr.r.rs == '0) ? kindSrl : kindInvalid;
                                        functSra:   kind = (instr.r.rs == '0) ? kindSra : kindInvalid;
                                        // Variable shifts need shamt clear
                                        functSllv:  kind = (instr.r.shamt == '0) ? kindSllv : kindInvalid;
                                        functSrlv:  kind = (instr.r.shamt == '0) ? kindSrlv : kindInvalid;
                                        functSrav:  kind = (instr.r.shamt == '0) ? kindSrav : kindInvalid;
                                        default:    kind = kindInvalid;   // Break, syscall and unknown
                                endcase
                        end

                        opRegImm: begin
                                case (instr.i.rt)
                                        rtBltz:   kind = kindBltz;
                                        rtBgez:   kind = kindBgez;
                                        rtBltzal: kind = kindBltzal;
                                        rtBgezal: kind = kindBgezal;
                                        default:  kind = kindInvalid;
                                endcase
                        end

                        opJ:     kind = kindJ;
                        opJal:   kind = kindJal;

                        opBeq:   kind = kindBeq;
                        opBne:   kind = kindBne;
                        opBlez:  kind = kindBlez;
                        opBgtz:  kind = kindBgtz;

                        opAddi:  kind = kindAddi;
                        opAddiu: kind = kindAddiu;
                        opSlti:  kind = kindSlti;
                        opSltiu: kind = kindSltiu;
                        opAndi:  kind = kindAndi;
                        opOri:   kind = kindOri;
                        opXori:  kind = kindXori;
                        opLui:   kind = kindLui;

                        default: kind = kindInvalid;        // Loads, stores, COP0 and the rest
                endcase
        end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tbDecodeStage \
        -f filelist.f -o simDecode || exit 1
result=$(./obj_dir/simDecode)
echo "$result"
echo "$result" | grep -qx "TEST PASSED" && exit 0 || exit 1

//--- tbDecodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module tbDecodeStage
        import decodePkg::*;
();

        localparam int MaxCases  = 64;
        localparam int ClkPeriod = 4;

        logic      clk;
        logic      reset;
        logic      instrValid;
        instrWordT instr;
        logic      ctrlValid;
        controlT   ctrl;

        logic [31:0] caseMem [0:2*MaxCases-1];  // Word and expected bundle, alternating
        int          numCases;
        int          cycleLimit = 40;           // Raised once the cases are loaded
        int          cycleCount = 0;
        int          checkCount = 0;
        int          errorCount = 0;

        int          expIdxQ [$];
        controlT     expCtrlQ [$];
        logic        lastValid;                 // Valid bit driven one cycle earlier
        controlT     lastCtrl;                  // Bundle the DUT should hold while idle

        decodeStage i_decodeStage (
                .clk        (clk),
                .reset      (reset),
                .instrValid (instrValid),
                .instr      (instr),
                .ctrlValid  (ctrlValid),
                .ctrl       (ctrl)
        );

        initial begin
                clk = 1'b0;
                forever #(ClkPeriod/2) clk = ~clk;
        end

        always @(posedge clk) begin
                cycleCount++;
                if (cycleCount >= cycleLimit) begin
                        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        ////////////////////////////////////////
        // Checking
        ////////////////////////////////////////
        task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
                checkCount++;
                if (got !== exp) begin
                        errorCount++;
                        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
                end
        endtask

        // Called on the falling edge, before new inputs go out
        task automatic sampleOutputs();
                int      idx;
                controlT expCtrl;
                checkValue(32'(ctrlValid), 32'(lastValid), "ctrlValid");
                if (ctrlValid) begin
                        if (expCtrlQ.size() == 0) begin
                                errorCount++;
                                $display("At %0t the DUT gave a result with no case outstanding",
                                         $time);
                        end else begin
                                idx     = expIdxQ.pop_front();
                                expCtrl = expCtrlQ.pop_front();
                                checkValue(32'(ctrl), 32'(expCtrl),
                                           $sformatf("case %0d ctrl", idx));
                                lastCtrl = expCtrl;
                        end
                end else begin
                        checkValue(32'(ctrl), 32'(lastCtrl), "ctrl hold while idle");
                end
        endtask

        ////////////////////////////////////////
        // Stimulus
        ////////////////////////////////////////
        task automatic driveCase(input int idx);
                @(negedge clk);
                sampleOutputs();
                instrValid = 1'b1;
                instr      = caseMem[2*idx];
                expIdxQ.push_back(idx);
                expCtrlQ.push_back(caseMem[2*idx+1][23:0]);
                lastValid  = 1'b1;
        endtask

        task automatic idleCycle();
                @(negedge clk);
                sampleOutputs();
                instrValid = 1'b0;
                instr      = $urandom;          // Junk word must not reach ctrl
                lastValid  = 1'b0;
        endtask

        task automatic reportGroup(input string name, input int errorsAtStart);
                $display("%s: finished, %0d errors", name, errorCount - errorsAtStart);
        endtask

        initial begin
                int i;
                int gap;
                int groupStart;

                void'($urandom(32'h9e01));
                reset      = 1'b1;
                instrValid = 1'b0;
                instr      = '0;
                lastValid  = 1'b0;
                lastCtrl   = '0;

                for (i = 0; i < 2*MaxCases; i++) begin
                        caseMem[i] = {8'hff, 24'(i)};   // Nonzero top byte marks an empty slot
                end
                $readmemh("decodeCases.txt", caseMem);
                numCases = 0;
                while (numCases < MaxCases && caseMem[2*numCases+1][31:24] == 8'h00) begin
                        numCases++;
                end
                if (numCases == 0) begin
                        errorCount++;
                        $display("No cases were read from decodeCases.txt");
                end
                cycleLimit = numCases * 5 + 40;

                // Reset for 4 cycles, release on a falling edge
                groupStart = errorCount;
                repeat (4) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                checkValue(32'(ctrlValid), 32'd0, "ctrlValid after reset");
                checkValue(32'(ctrl.regsWr), 32'd0, "write enables after reset");
                idleCycle();
                idleCycle();
                reportGroup("reset", groupStart);

                groupStart = errorCount;
                for (i = 0; i < numCases; i++) begin
                        driveCase(i);
                end
                idleCycle();
                idleCycle();
                reportGroup("back-to-back cases", groupStart);

                groupStart = errorCount;
                for (i = 0; i < numCases; i++) begin
                        driveCase(i);
                        if ($urandom % 2 == 1) begin
                                gap = 1 + $urandom % 3;
                                repeat (gap) idleCycle();
                        end
                end
                idleCycle();
                idleCycle();
                reportGroup("cases with idle gaps", groupStart);

                if (expCtrlQ.size() != 0) begin
                        errorCount++;
                        $display("%0d driven cases never came out of the DUT", expCtrlQ.size());
                end
                $display("cases %0d, checks %0d, errors %0d", numCases, checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire
